/* include/uart_axil_consts.svh */
/*
 * Bus widths, response sizing, ASCII codes and the default
 * baud divider for the UART to AXI4-Lite bridge
 */

`ifndef UART_AXIL_CONSTS_SVH
`define UART_AXIL_CONSTS_SVH

// AXI4-Lite bus
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Read reply is "0x" + digits + LF
`define DATA_HEX_DIGITS 8
`define RSP_MAX_LEN 11

// 100 MHz clock at 115200 baud
`define DEF_CLKS_PER_BIT 868

// Characters the parser cares about
`define ASCII_SPACE 8'h20
`define ASCII_LF 8'h0A
`define ASCII_CR 8'h0D

`endif

/* rtl/uart_axil_pkg.sv */
/*
 * Command opcode, parser state and AXI master state types
 */

`default_nettype none

package uart_axil_pkg;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } cmd_op_t;

    typedef enum logic [1:0] {
        P_IDLE,
        P_ADDR,
        P_DATA,
        P_WAIT
    } parse_state_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_AW,
        M_W,
        M_B,
        M_AR,
        M_R
    } axil_state_t;

endpackage

`default_nettype wire

/* rtl/bus_cmd_if.sv */
/*
 * Command channel from the parser to the AXI master,
 * with completion observed by the response formatter
 */

`timescale 1ns/10ps
`default_nettype none

`include "uart_axil_consts.svh"

interface bus_cmd_if import uart_axil_pkg::*; ();

    // Request, held stable while req_valid is high
    logic                    req_valid;
    cmd_op_t                 req_op;
    logic [`AXIL_ADDR_W-1:0] req_addr;
    logic [`AXIL_DATA_W-1:0] req_data;

    // Completion, done is a single-cycle pulse
    logic                    done;
    logic [`AXIL_DATA_W-1:0] rdata;

    modport parser (output req_valid, req_op, req_addr, req_data, input done);
    modport master (input req_valid, req_op, req_addr, req_data, output done, rdata);
    modport monitor (input req_op, done, rdata);

endinterface

`default_nettype wire

/* rtl/uart_rx.sv */
/*
 * UART receiver, 8N1
 * Two-flop line synchroniser, mid-bit sampling, byte strobe
 */

`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire logic       aclk,
    input  wire logic       i_rst,
    input  wire logic       i_rx,
    output logic [7:0]      o_data,
    output logic            o_strobe
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [1:0]       r_sync;
    logic             r_busy;
    logic [CNT_W-1:0] r_cnt;
    logic [3:0]       r_bit;
    logic             w_line;

    assign w_line = r_sync[1];

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            r_sync   <= 2'b11;
            r_busy   <= 1'b0;
            r_cnt    <= '0;
            r_bit    <= '0;
            o_strobe <= 1'b0;
        end else begin
            r_sync   <= {r_sync[0], i_rx};
            o_strobe <= 1'b0;
            if (!r_busy) begin
                // Start edge, first sample lands mid start bit
                if (!w_line) begin
                    r_busy <= 1'b1;
                    r_cnt  <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                    r_bit  <= '0;
                end
            end else if (r_cnt != '0) begin
                r_cnt <= r_cnt - 1'b1;
            end else begin
                r_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                r_bit <= r_bit + 1'b1;
                if (r_bit == 4'd0) begin
                    // Glitch, not a real start bit
                    if (w_line) begin
                        r_busy <= 1'b0;
                    end
                end else if (r_bit == 4'd9) begin
                    r_busy   <= 1'b0;
                    o_strobe <= w_line;
                end else begin
                    o_data <= {w_line, o_data[7:1]};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
/*
 * UART transmitter, 8N1
 * Accepts a byte while idle and shifts out start, data LSB first, stop
 */

`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire logic       aclk,
    input  wire logic       i_rst,
    input  wire logic [7:0] i_data,
    input  wire logic       i_valid,
    output logic            o_ready,
    output logic            o_tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic             r_busy;
    logic [9:0]       r_shift;
    logic [CNT_W-1:0] r_cnt;
    logic [3:0]       r_bit;

    assign o_ready = !r_busy;
    assign o_tx    = r_busy ? r_shift[0] : 1'b1;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            r_busy <= 1'b0;
            r_cnt  <= '0;
            r_bit  <= '0;
        end else if (!r_busy) begin
            if (i_valid) begin
                // Frame is stop, data, start
                r_shift <= {1'b1, i_data, 1'b0};
                r_busy  <= 1'b1;
                r_cnt   <= '0;
                r_bit   <= '0;
            end
        end else if (r_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            r_cnt   <= '0;
            r_shift <= {1'b1, r_shift[9:1]};
            r_bit   <= r_bit + 1'b1;
            if (r_bit == 4'd9) begin
                r_busy <= 1'b0;
            end
        end else begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/cmd_parser.sv */
/*
 * Command parser for "W <addr> <data>" and "R <addr>" lines
 * Decodes hex fields and hands one request to the AXI master
 */

`timescale 1ns/10ps
`default_nettype none

`include "uart_axil_consts.svh"

module cmd_parser import uart_axil_pkg::*; (
    input  wire logic       aclk,
    input  wire logic       i_rst,
    input  wire logic [7:0] i_rx_data,
    input  wire logic       i_rx_strobe,
    input  wire logic       i_rsp_sent,
    bus_cmd_if.parser       cmd
);

    parse_state_t r_state;
    logic [3:0]   r_nibbles;
    logic [4:0]   w_hex;
    logic         w_term;
    logic         w_space;

    // Bit 4 flags a hex digit, low bits are its value
    function automatic logic [4:0] hex_decode(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return {1'b1, 4'(c - "0")};
        end else if (c >= "a" && c <= "f") begin
            return {1'b1, 4'(c - "a" + 8'd10)};
        end else if (c >= "A" && c <= "F") begin
            return {1'b1, 4'(c - "A" + 8'd10)};
        end
        return 5'd0;
    endfunction

    assign w_hex   = hex_decode(i_rx_data);
    assign w_term  = (i_rx_data == `ASCII_LF) || (i_rx_data == `ASCII_CR);
    assign w_space = (i_rx_data == `ASCII_SPACE);

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            r_state       <= P_IDLE;
            r_nibbles     <= '0;
            cmd.req_valid <= 1'b0;
        end else begin
            case (r_state)
                P_IDLE: begin
                    if (i_rx_strobe && (i_rx_data == "W" || i_rx_data == "w" ||
                                        i_rx_data == "R" || i_rx_data == "r")) begin
                        cmd.req_op   <= (i_rx_data == "W" || i_rx_data == "w") ?
                                        OP_WRITE : OP_READ;
                        cmd.req_addr <= '0;
                        cmd.req_data <= '0;
                        r_nibbles    <= '0;
                        r_state      <= P_ADDR;
                    end
                end
                P_ADDR: begin
                    if (i_rx_strobe) begin
                        if (w_hex[4]) begin
                            cmd.req_addr <= {cmd.req_addr[`AXIL_ADDR_W-5:0], w_hex[3:0]};
                            if (r_nibbles != 4'hF) begin
                                r_nibbles <= r_nibbles + 1'b1;
                            end
                        end else if (w_space && r_nibbles != '0) begin
                            if (cmd.req_op == OP_WRITE) begin
                                r_nibbles <= '0;
                                r_state   <= P_DATA;
                            end else begin
                                cmd.req_valid <= 1'b1;
                                r_state       <= P_WAIT;
                            end
                        end else if (w_term) begin
                            cmd.req_valid <= 1'b1;
                            r_state       <= P_WAIT;
                        end
                    end
                end
                P_DATA: begin
                    if (i_rx_strobe) begin
                        if (w_hex[4]) begin
                            cmd.req_data <= {cmd.req_data[`AXIL_DATA_W-5:0], w_hex[3:0]};
                        end else if (w_term) begin
                            cmd.req_valid <= 1'b1;
                            r_state       <= P_WAIT;
                        end
                    end
                end
                P_WAIT: begin
                    // Request held until done, then wait for the reply to go out
                    if (cmd.done) begin
                        cmd.req_valid <= 1'b0;
                    end
                    if (i_rsp_sent) begin
                        r_state <= P_IDLE;
                    end
                end
                default: r_state <= P_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/axil_master.sv */
/*
 * AXI4-Lite master sequencer
 * Write is AW, W, then B; read is AR then R; all outputs registered
 */

`timescale 1ns/10ps
`default_nettype none

`include "uart_axil_consts.svh"

module axil_master import uart_axil_pkg::*; (
    input  wire logic                    aclk,
    input  wire logic                    i_rst,
    bus_cmd_if.master                    cmd,
    output logic [`AXIL_ADDR_W-1:0]      o_awaddr,
    output logic                         o_awvalid,
    input  wire logic                    i_awready,
    output logic [`AXIL_DATA_W-1:0]      o_wdata,
    output logic                         o_wvalid,
    input  wire logic                    i_wready,
    input  wire logic                    i_bvalid,
    output logic                         o_bready,
    output logic [`AXIL_ADDR_W-1:0]      o_araddr,
    output logic                         o_arvalid,
    input  wire logic                    i_arready,
    input  wire logic [`AXIL_DATA_W-1:0] i_rdata,
    input  wire logic                    i_rvalid,
    output logic                         o_rready
);

    axil_state_t r_state;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            r_state   <= M_IDLE;
            o_awvalid <= 1'b0;
            o_wvalid  <= 1'b0;
            o_bready  <= 1'b0;
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
            cmd.done  <= 1'b0;
        end else begin
            cmd.done <= 1'b0;
            case (r_state)
                M_IDLE: begin
                    // Request is still up during the done cycle, skip it
                    if (cmd.req_valid && !cmd.done) begin
                        o_awaddr <= cmd.req_addr;
                        o_araddr <= cmd.req_addr;
                        if (cmd.req_op == OP_WRITE) begin
                            o_awvalid <= 1'b1;
                            r_state   <= M_AW;
                        end else begin
                            o_arvalid <= 1'b1;
                            r_state   <= M_AR;
                        end
                    end
                end
                M_AW: begin
                    if (i_awready) begin
                        o_awvalid <= 1'b0;
                        o_wdata   <= cmd.req_data;
                        o_wvalid  <= 1'b1;
                        r_state   <= M_W;
                    end
                end
                M_W: begin
                    if (i_wready) begin
                        o_wvalid <= 1'b0;
                        o_bready <= 1'b1;
                        r_state  <= M_B;
                    end
                end
                M_B: begin
                    if (i_bvalid) begin
                        o_bready <= 1'b0;
                        cmd.done <= 1'b1;
                        r_state  <= M_IDLE;
                    end
                end
                M_AR: begin
                    if (i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                        r_state   <= M_R;
                    end
                end
                M_R: begin
                    if (i_rvalid) begin
                        o_rready  <= 1'b0;
                        cmd.rdata <= i_rdata;
                        cmd.done  <= 1'b1;
                        r_state   <= M_IDLE;
                    end
                end
                default: r_state <= M_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/rsp_formatter.sv */
/*
 * Response formatter
 * Builds "OK" or "0x" plus hex digits, ends with LF, streams to the UART
 */

`timescale 1ns/10ps
`default_nettype none

`include "uart_axil_consts.svh"

module rsp_formatter import uart_axil_pkg::*; (
    input  wire logic       aclk,
    input  wire logic       i_rst,
    bus_cmd_if.monitor      cmd,
    output logic [7:0]      o_tx_data,
    output logic            o_tx_valid,
    input  wire logic       i_tx_ready,
    output logic            o_rsp_sent
);

    localparam int IDX_W = $clog2(`RSP_MAX_LEN);

    logic [7:0]       r_buf [`RSP_MAX_LEN];
    logic [IDX_W-1:0] r_idx;
    logic [IDX_W-1:0] r_len;

    function automatic logic [7:0] val_to_hex(input logic [3:0] v);
        return (v < 4'd10) ? 8'("0") + 8'(v) : 8'("A") + 8'(v) - 8'd10;
    endfunction

    assign o_tx_data = r_buf[r_idx];

    // Response text
    always_ff @(posedge aclk) begin
        if (cmd.done) begin
            if (cmd.req_op == OP_WRITE) begin
                r_buf[0] <= "O";
                r_buf[1] <= "K";
                r_buf[2] <= `ASCII_LF;
                r_len    <= IDX_W'(3);
            end else begin
                r_buf[0] <= "0";
                r_buf[1] <= "x";
                for (int i = 0; i < `DATA_HEX_DIGITS; i++) begin
                    r_buf[2 + i] <= val_to_hex(cmd.rdata[`AXIL_DATA_W-1-4*i -: 4]);
                end
                r_buf[`RSP_MAX_LEN-1] <= `ASCII_LF;
                r_len                 <= IDX_W'(`RSP_MAX_LEN);
            end
        end
    end

    // Byte stepping
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            r_idx      <= '0;
            o_tx_valid <= 1'b0;
            o_rsp_sent <= 1'b0;
        end else begin
            o_rsp_sent <= 1'b0;
            if (cmd.done) begin
                r_idx      <= '0;
                o_tx_valid <= 1'b1;
            end else if (o_tx_valid && i_tx_ready) begin
                if (r_idx == r_len - 1'b1) begin
                    o_tx_valid <= 1'b0;
                    o_rsp_sent <= 1'b1;
                end else begin
                    r_idx <= r_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_axil_bridge.sv */
/*
 * UART to AXI4-Lite master bridge top level
 * UART RX/TX, command parser, AXI master and response formatter
 */

`timescale 1ns/10ps
`default_nettype none

`include "uart_axil_consts.svh"

module uart_axil_bridge #(
    parameter int CLKS_PER_BIT = `DEF_CLKS_PER_BIT
) (
    input  wire logic                    aclk,
    input  wire logic                    i_rst,
    input  wire logic                    i_uart_rx,
    output logic                         o_uart_tx,
    output logic [`AXIL_ADDR_W-1:0]      o_m_axil_awaddr,
    output logic                         o_m_axil_awvalid,
    input  wire logic                    i_m_axil_awready,
    output logic [`AXIL_DATA_W-1:0]      o_m_axil_wdata,
    output logic                         o_m_axil_wvalid,
    input  wire logic                    i_m_axil_wready,
    input  wire logic                    i_m_axil_bvalid,
    output logic                         o_m_axil_bready,
    output logic [`AXIL_ADDR_W-1:0]      o_m_axil_araddr,
    output logic                         o_m_axil_arvalid,
    input  wire logic                    i_m_axil_arready,
    input  wire logic [`AXIL_DATA_W-1:0] i_m_axil_rdata,
    input  wire logic                    i_m_axil_rvalid,
    output logic                         o_m_axil_rready
);

    logic [7:0] w_rx_data;
    logic       w_rx_strobe;
    logic [7:0] w_tx_data;
    logic       w_tx_valid;
    logic       w_tx_ready;
    logic       w_rsp_sent;

    bus_cmd_if u_cmd ();

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .aclk     (aclk),
        .i_rst    (i_rst),
        .i_rx     (i_uart_rx),
        .o_data   (w_rx_data),
        .o_strobe (w_rx_strobe)
    );

    // Strobes outside P_IDLE/P_ADDR/P_DATA are dropped by the parser
    cmd_parser u_parser (
        .aclk        (aclk),
        .i_rst       (i_rst),
        .i_rx_data   (w_rx_data),
        .i_rx_strobe (w_rx_strobe),
        .i_rsp_sent  (w_rsp_sent),
        .cmd         (u_cmd.parser)
    );

    axil_master u_master (
        .aclk      (aclk),
        .i_rst     (i_rst),
        .cmd       (u_cmd.master),
        .o_awaddr  (o_m_axil_awaddr),
        .o_awvalid (o_m_axil_awvalid),
        .i_awready (i_m_axil_awready),
        .o_wdata   (o_m_axil_wdata),
        .o_wvalid  (o_m_axil_wvalid),
        .i_wready  (i_m_axil_wready),
        .i_bvalid  (i_m_axil_bvalid),
        .o_bready  (o_m_axil_bready),
        .o_araddr  (o_m_axil_araddr),
        .o_arvalid (o_m_axil_arvalid),
        .i_arready (i_m_axil_arready),
        .i_rdata   (i_m_axil_rdata),
        .i_rvalid  (i_m_axil_rvalid),
        .o_rready  (o_m_axil_rready)
    );

    rsp_formatter u_formatter (
        .aclk       (aclk),
        .i_rst      (i_rst),
        .cmd        (u_cmd.monitor),
        .o_tx_data  (w_tx_data),
        .o_tx_valid (w_tx_valid),
        .i_tx_ready (w_tx_ready),
        .o_rsp_sent (w_rsp_sent)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .aclk    (aclk),
        .i_rst   (i_rst),
        .i_data  (w_tx_data),
        .i_valid (w_tx_valid),
        .o_ready (w_tx_ready),
        .o_tx    (o_uart_tx)
    );

endmodule

`default_nettype wire

/* testbench/tb_axil_slave.sv */
/*
 * AXI4-Lite memory model for the bridge testbench
 * 256 words, random 0 to 3 cycle ready and response delays
 */

`timescale 1ns/10ps
`default_nettype none

module tb_axil_slave (
    input  wire logic        aclk,
    input  wire logic        i_rst,
    input  wire logic [31:0] i_awaddr,
    input  wire logic        i_awvalid,
    output logic             o_awready,
    input  wire logic [31:0] i_wdata,
    input  wire logic        i_wvalid,
    output logic             o_wready,
    output logic             o_bvalid,
    input  wire logic        i_bready,
    input  wire logic [31:0] i_araddr,
    input  wire logic        i_arvalid,
    output logic             o_arready,
    output logic [31:0]      o_rdata,
    output logic             o_rvalid,
    input  wire logic        i_rready
);

    // Word-indexed by the low eight address bits
    logic [31:0] mem [256];
    logic [7:0]  waddr;
    logic [1:0]  aw_dly;
    logic [1:0]  w_dly;
    logic [1:0]  b_dly;
    logic [1:0]  ar_dly;
    logic [1:0]  r_dly;
    logic        b_pend;
    logic        r_pend;

    // Memory starts cleared, channel outputs idle
    initial begin
        int i;
        for (i = 0; i < 256; i++) begin
            mem[8'(i)] = '0;
        end
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        o_arready = 1'b0;
        o_rdata   = '0;
        o_rvalid  = 1'b0;
    end

    always @(posedge aclk) begin
        if (i_rst) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            b_pend    <= 1'b0;
            r_pend    <= 1'b0;
            aw_dly    <= '0;
            w_dly     <= '0;
            ar_dly    <= '0;
        end else begin
            // Ready is a one-cycle pulse after the delay runs out
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_arready <= 1'b0;

            if (i_awvalid && o_awready) begin
                waddr  <= i_awaddr[7:0];
                aw_dly <= 2'($urandom);
            end else if (i_awvalid) begin
                if (aw_dly == 2'd0) begin
                    o_awready <= 1'b1;
                end else begin
                    aw_dly <= aw_dly - 2'd1;
                end
            end

            if (i_wvalid && o_wready) begin
                mem[waddr] <= i_wdata;
                w_dly      <= 2'($urandom);
                b_dly      <= 2'($urandom);
                b_pend     <= 1'b1;
            end else if (i_wvalid) begin
                if (w_dly == 2'd0) begin
                    o_wready <= 1'b1;
                end else begin
                    w_dly <= w_dly - 2'd1;
                end
            end

            // Write response held until accepted
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end else if (b_pend) begin
                if (b_dly == 2'd0) begin
                    o_bvalid <= 1'b1;
                    b_pend   <= 1'b0;
                end else begin
                    b_dly <= b_dly - 2'd1;
                end
            end

            if (i_arvalid && o_arready) begin
                o_rdata <= mem[i_araddr[7:0]];
                ar_dly  <= 2'($urandom);
                r_dly   <= 2'($urandom);
                r_pend  <= 1'b1;
            end else if (i_arvalid) begin
                if (ar_dly == 2'd0) begin
                    o_arready <= 1'b1;
                end else begin
                    ar_dly <= ar_dly - 2'd1;
                end
            end

            if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
            end else if (r_pend) begin
                if (r_dly == 2'd0) begin
                    o_rvalid <= 1'b1;
                    r_pend   <= 1'b0;
                end else begin
                    r_dly <= r_dly - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_uart_axil_bridge.sv */
/*
 * Testbench for the UART to AXI4-Lite bridge
 * Clock, reset, UART driver and TX monitor, directed tests, watchdog
 */

`timescale 1ns/10ps
`default_nettype none

module tb_uart_axil_bridge;

    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int SEED         = 32'hd938;
    localparam int RAND_PAIRS   = 20;
    localparam logic [7:0] LF   = 8'h0A;

    // Generous bound on one reply line of up to 11 bytes
    localparam int LINE_TIMEOUT = 2 * 16 * 10 * CLKS_PER_BIT;
    // Four byte times is enough for any reply to start
    localparam int QUIET_CYCLES = 4 * 10 * CLKS_PER_BIT;
    // Each command and reply exchange stays under 40 bytes on the lines
    localparam int NUM_EXCHANGES = 1 + 2 + 2 + 2 + 2 * RAND_PAIRS + 3;
    localparam int WATCHDOG_NS =
        NUM_EXCHANGES * 40 * 10 * CLKS_PER_BIT * CLK_PERIOD * 2;

    logic        aclk;
    logic        rst;
    logic        uart_rx_line;
    logic        uart_tx_line;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;

    logic [7:0]  tx_bytes [$];
    int          errors;
    int          checks;

    uart_axil_bridge #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_axil_bridge_i (
        .aclk             (aclk),
        .i_rst            (rst),
        .i_uart_rx        (uart_rx_line),
        .o_uart_tx        (uart_tx_line),
        .o_m_axil_awaddr  (awaddr),
        .o_m_axil_awvalid (awvalid),
        .i_m_axil_awready (awready),
        .o_m_axil_wdata   (wdata),
        .o_m_axil_wvalid  (wvalid),
        .i_m_axil_wready  (wready),
        .i_m_axil_bvalid  (bvalid),
        .o_m_axil_bready  (bready),
        .o_m_axil_araddr  (araddr),
        .o_m_axil_arvalid (arvalid),
        .i_m_axil_arready (arready),
        .i_m_axil_rdata   (rdata),
        .i_m_axil_rvalid  (rvalid),
        .o_m_axil_rready  (rready)
    );

    tb_axil_slave u_slave (
        .aclk      (aclk),
        .i_rst     (rst),
        .i_awaddr  (awaddr),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_wdata   (wdata),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_bvalid  (bvalid),
        .i_bready  (bready),
        .i_araddr  (araddr),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_rdata   (rdata),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Called and returns 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            uart_rx_line = frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (CLKS_PER_BIT) @(posedge aclk);
            #1;
        end
    endtask

    task automatic send_string(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    // Decodes TX frames on falling clock edges where the line is stable
    task automatic decode_tx();
        logic [7:0] b;
        int i;
        forever begin
            @(negedge uart_tx_line);
            repeat (CLKS_PER_BIT / 2) @(negedge aclk);
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge aclk);
                b = {uart_tx_line, b[7:1]};
            end
            repeat (CLKS_PER_BIT) @(negedge aclk);
            checks++;
            assert (uart_tx_line == 1'b1) else begin
                $display("Error at %0d ns: TX stop bit is low", $time);
                errors++;
            end
            tx_bytes.push_back(b);
        end
    endtask

    // Collects monitored bytes up to LF and drops the LF
    task automatic recv_line(output string line, output bit complete);
        int waited;
        logic [7:0] c;
        line = "";
        complete = 1'b0;
        waited = 0;
        while (!complete && waited < LINE_TIMEOUT) begin
            @(posedge aclk);
            #1;
            waited++;
            while (!complete && tx_bytes.size() != 0) begin
                c = tx_bytes.pop_front();
                if (c == LF) begin
                    complete = 1'b1;
                end else begin
                    line = $sformatf("%s%c", line, c);
                end
            end
        end
    endtask

    function automatic string read_reply(input logic [31:0] v);
        string digits;
        digits = $sformatf("%08h", v);
        return {"0x", digits.toupper()};
    endfunction

    task automatic expect_reply(input string cmd, input string exp);
        string got;
        bit complete;
        send_string(cmd);
        recv_line(got, complete);
        checks++;
        assert (complete) else begin
            $display("No complete reply line by %0d ns, expected %s", $time, exp);
            errors++;
        end
        if (complete) begin
            checks++;
            assert (got == exp) else begin
                $display("Error at %0d ns: reply %s, expected %s", $time, got, exp);
                errors++;
            end
        end
    endtask

    task automatic check_mem(input logic [7:0] addr, input logic [31:0] exp);
        checks++;
        assert (u_slave.mem[addr] == exp) else begin
            $display("Error at %0d ns: memory[%02h] is %08h, expected %08h",
                     $time, addr, u_slave.mem[addr], exp);
            errors++;
        end
    endtask

    task automatic print_result(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("[%0d ns] %s: PASS", $time, name);
        end else begin
            $display("[%0d ns] %s: FAIL, %0d errors", $time, name, errors - errs_before);
        end
    endtask

    task automatic write_word();
        int errs_before;
        errs_before = errors;
        expect_reply("W 10 CAFEF00D\n", "OK");
        check_mem(8'h10, 32'hCAFEF00D);
        print_result("write", errs_before);
    endtask

    task automatic read_back();
        int errs_before;
        errs_before = errors;
        expect_reply("R 10\n", "0xCAFEF00D");
        expect_reply("R 20\n", "0x00000000");
        print_result("read", errs_before);
    endtask

    task automatic mixed_case_lines();
        int errs_before;
        errs_before = errors;
        expect_reply("w   2c beef1234\r", "OK");
        check_mem(8'h2c, 32'hBEEF1234);
        expect_reply("r  2c\r", "0xBEEF1234");
        print_result("case and terminators", errs_before);
    endtask

    task automatic ignore_unknown_letter();
        int errs_before;
        errs_before = errors;
        send_string("X 10\n");
        repeat (QUIET_CYCLES) @(posedge aclk);
        #1;
        checks++;
        assert (tx_bytes.size() == 0) else begin
            $display("Unknown command got a reply of %0d bytes at %0d ns",
                     tx_bytes.size(), $time);
            errors++;
            tx_bytes.delete();
        end
        expect_reply("R 10\n", "0xCAFEF00D");
        print_result("unknown first character", errs_before);
    endtask

    task automatic random_pairs();
        int errs_before;
        int i;
        logic [7:0] addr;
        logic [31:0] data;
        string letter;
        errs_before = errors;
        for (i = 0; i < RAND_PAIRS; i++) begin
            addr = 8'($urandom);
            data = $urandom;
            if (i % 2 == 0) begin
                letter = "W";
            end else begin
                letter = "w";
            end
            expect_reply($sformatf("%s %h %h\n", letter, addr, data), "OK");
            check_mem(addr, data);
            expect_reply($sformatf("R %h\n", addr), read_reply(data));
        end
        print_result("back-pressure", errs_before);
    endtask

    initial begin
        @(negedge rst);
        decode_tx();
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0d ns before the tests finished", $time);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        uart_rx_line = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        rst = 1'b0;
        // Idle line through the receiver synchroniser
        repeat (4) @(posedge aclk);
        #1;

        write_word();
        read_back();
        mixed_case_lines();
        ignore_unknown_letter();
        random_pairs();

        $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
rtl/uart_axil_pkg.sv
rtl/bus_cmd_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_parser.sv
rtl/axil_master.sv
rtl/rsp_formatter.sv
rtl/uart_axil_bridge.sv
testbench/tb_axil_slave.sv
testbench/tb_uart_axil_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART to AXI4-Lite bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module tb_uart_axil_bridge \
    -f sources.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
